//--- source/exu_pkg.sv
// Shared widths, operation codes and stage payloads of the execute unit
// Codes 30 and 31 are unused and decode as illegal

`default_nettype none

package exu_pkg;

	localparam int XLEN  = 32;
	localparam int OP_W  = 5;
	localparam int TAG_W = 4;
	localparam int CNT_W = 16;

	// Extension enable vector
	localparam int EXT_W   = 2;
	localparam int EXT_ZBA = 0;
	localparam int EXT_ZBB = 1;
	localparam logic [EXT_W-1:0] EXT_RESET = 2'b11;	// Both on after reset

	// Base integer set
	localparam logic [OP_W-1:0] OP_ADD  = 5'd0;
	localparam logic [OP_W-1:0] OP_SUB  = 5'd1;
	localparam logic [OP_W-1:0] OP_AND  = 5'd2;
	localparam logic [OP_W-1:0] OP_OR   = 5'd3;
	localparam logic [OP_W-1:0] OP_XOR  = 5'd4;
	localparam logic [OP_W-1:0] OP_SLL  = 5'd5;
	localparam logic [OP_W-1:0] OP_SRL  = 5'd6;
	localparam logic [OP_W-1:0] OP_SRA  = 5'd7;
	localparam logic [OP_W-1:0] OP_SLT  = 5'd8;
	localparam logic [OP_W-1:0] OP_SLTU = 5'd9;
	localparam logic [OP_W-1:0] OP_EQ   = 5'd10;
	localparam logic [OP_W-1:0] OP_NE   = 5'd11;
	localparam logic [OP_W-1:0] OP_GE   = 5'd12;
	localparam logic [OP_W-1:0] OP_GEU  = 5'd13;

	// Zba
	localparam logic [OP_W-1:0] OP_SH1ADD = 5'd14;
	localparam logic [OP_W-1:0] OP_SH2ADD = 5'd15;
	localparam logic [OP_W-1:0] OP_SH3ADD = 5'd16;

	// Zbb
	localparam logic [OP_W-1:0] OP_ANDN  = 5'd17;
	localparam logic [OP_W-1:0] OP_ORN   = 5'd18;
	localparam logic [OP_W-1:0] OP_XNOR  = 5'd19;
	localparam logic [OP_W-1:0] OP_MAX   = 5'd20;
	localparam logic [OP_W-1:0] OP_MAXU  = 5'd21;
	localparam logic [OP_W-1:0] OP_MIN   = 5'd22;
	localparam logic [OP_W-1:0] OP_MINU  = 5'd23;
	localparam logic [OP_W-1:0] OP_SEXTB = 5'd24;
	localparam logic [OP_W-1:0] OP_SEXTH = 5'd25;
	localparam logic [OP_W-1:0] OP_REV8  = 5'd26;
	localparam logic [OP_W-1:0] OP_ORCB  = 5'd27;
	localparam logic [OP_W-1:0] OP_ROL   = 5'd28;
	localparam logic [OP_W-1:0] OP_ROR   = 5'd29;

	// Request payload, 73 bits
	typedef struct packed {
		logic [OP_W-1:0]  op;
		logic [XLEN-1:0]  op1;
		logic [XLEN-1:0]  op2;
		logic [TAG_W-1:0] tag;
	} exu_req_t;

	// Response payload, 37 bits
	typedef struct packed {
		logic [XLEN-1:0]  result;
		logic             illegal;
		logic [TAG_W-1:0] tag;
	} exu_rsp_t;

endpackage

`default_nettype wire

//--- source/exu_pipe_reg.sv
// One-entry valid/ready register stage, full throughput
// Ready upstream depends combinationally on ready downstream

`timescale 1ns/1ps
`default_nettype none

module exu_pipe_reg #(
	parameter type T = logic
)(
	input wire i_clk,
	input wire i_arst_n,

	input wire i_valid,
	output logic o_ready,
	input wire T i_data,

	output logic o_valid,
	input wire i_ready,
	output T o_data
);

	logic valid_q;
	T data_q;

	// Empty, or the held entry leaves this cycle
	assign o_ready = !valid_q || i_ready;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			valid_q <= 1'b0;
		end else if (o_ready) begin
			valid_q <= i_valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_ready && i_valid) begin
			data_q <= i_data;
		end
	end

	assign o_valid = valid_q;
	assign o_data = data_q;

endmodule

`default_nettype wire

//--- source/exu_alu.sv
// Combinational RV32 ALU with the base set, Zba and Zbb
// Disabled extensions and unused codes give result 0 with o_illegal high

`timescale 1ns/1ps
`default_nettype none

module exu_alu(
	input wire [exu_pkg::OP_W-1:0] i_op,

	input wire [exu_pkg::XLEN-1:0] i_op1,
	input wire [exu_pkg::XLEN-1:0] i_op2,

	input wire [exu_pkg::EXT_W-1:0] i_enables,

	output logic [exu_pkg::XLEN-1:0] o_result,
	output logic o_illegal
);

	localparam int XLEN = exu_pkg::XLEN;

	wire [4:0] shamt = i_op2[4:0];
	wire [5:0] shamt_inv = 6'd32 - {1'b0, shamt};	// 32 when shamt is 0

	wire [XLEN-1:0] sum = i_op1 + i_op2;
	wire [XLEN-1:0] diff = i_op1 - i_op2;
	wire [XLEN-1:0] and_result = i_op1 & i_op2;
	wire [XLEN-1:0] or_result = i_op1 | i_op2;
	wire [XLEN-1:0] xor_result = i_op1 ^ i_op2;
	wire [XLEN-1:0] shl_result = i_op1 << shamt;
	wire [XLEN-1:0] shr_result = i_op1 >> shamt;
	wire [XLEN-1:0] ashr_result = $signed(i_op1) >>> shamt;

	wire signed_lt = $signed(i_op1) < $signed(i_op2);
	wire unsigned_lt = i_op1 < i_op2;
	wire equal = i_op1 == i_op2;

	// Zba
	wire [XLEN-1:0] sh1add_result = (i_op1 << 1) + i_op2;
	wire [XLEN-1:0] sh2add_result = (i_op1 << 2) + i_op2;
	wire [XLEN-1:0] sh3add_result = (i_op1 << 3) + i_op2;

	// Zbb
	wire [XLEN-1:0] andn_result = i_op1 & ~i_op2;
	wire [XLEN-1:0] orn_result = i_op1 | ~i_op2;
	wire [XLEN-1:0] xnor_result = ~xor_result;
	wire [XLEN-1:0] max_result = signed_lt ? i_op2 : i_op1;
	wire [XLEN-1:0] maxu_result = unsigned_lt ? i_op2 : i_op1;
	wire [XLEN-1:0] min_result = signed_lt ? i_op1 : i_op2;
	wire [XLEN-1:0] minu_result = unsigned_lt ? i_op1 : i_op2;
	wire [XLEN-1:0] sextb_result = {{24{i_op1[7]}}, i_op1[7:0]};
	wire [XLEN-1:0] sexth_result = {{16{i_op1[15]}}, i_op1[15:0]};
	wire [XLEN-1:0] rev8_result = {i_op1[7:0], i_op1[15:8], i_op1[23:16], i_op1[31:24]};
	wire [XLEN-1:0] orcb_result = {
		{8{|i_op1[31:24]}},
		{8{|i_op1[23:16]}},
		{8{|i_op1[15:8]}},
		{8{|i_op1[7:0]}}
	};
	wire [XLEN-1:0] rol_result = (i_op1 << shamt) | (i_op1 >> shamt_inv);
	wire [XLEN-1:0] ror_result = (i_op1 >> shamt) | (i_op1 << shamt_inv);

	wire zba_on = i_enables[exu_pkg::EXT_ZBA];
	wire zbb_on = i_enables[exu_pkg::EXT_ZBB];

	logic [XLEN-1:0] raw_result;
	logic legal;

	always_comb begin
		raw_result = '0;
		legal = 1'b1;
		case (i_op)
			exu_pkg::OP_ADD:  raw_result = sum;
			exu_pkg::OP_SUB:  raw_result = diff;
			exu_pkg::OP_AND:  raw_result = and_result;
			exu_pkg::OP_OR:   raw_result = or_result;
			exu_pkg::OP_XOR:  raw_result = xor_result;
			exu_pkg::OP_SLL:  raw_result = shl_result;
			exu_pkg::OP_SRL:  raw_result = shr_result;
			exu_pkg::OP_SRA:  raw_result = ashr_result;
			exu_pkg::OP_SLT:  raw_result = {{(XLEN-1){1'b0}}, signed_lt};
			exu_pkg::OP_SLTU: raw_result = {{(XLEN-1){1'b0}}, unsigned_lt};
			exu_pkg::OP_EQ:   raw_result = {{(XLEN-1){1'b0}}, equal};
			exu_pkg::OP_NE:   raw_result = {{(XLEN-1){1'b0}}, !equal};
			exu_pkg::OP_GE:   raw_result = {{(XLEN-1){1'b0}}, !signed_lt};
			exu_pkg::OP_GEU:  raw_result = {{(XLEN-1){1'b0}}, !unsigned_lt};
			exu_pkg::OP_SH1ADD: begin
				raw_result = sh1add_result;
				legal = zba_on;
			end
			exu_pkg::OP_SH2ADD: begin
				raw_result = sh2add_result;
				legal = zba_on;
			end
			exu_pkg::OP_SH3ADD: begin
				raw_result = sh3add_result;
				legal = zba_on;
			end
			exu_pkg::OP_ANDN: begin
				raw_result = andn_result;
				legal = zbb_on;
			end
			exu_pkg::OP_ORN: begin
				raw_result = orn_result;
				legal = zbb_on;
			end
			exu_pkg::OP_XNOR: begin
				raw_result = xnor_result;
				legal = zbb_on;
			end
			exu_pkg::OP_MAX: begin
				raw_result = max_result;
				legal = zbb_on;
			end
			exu_pkg::OP_MAXU: begin
				raw_result = maxu_result;
				legal = zbb_on;
			end
			exu_pkg::OP_MIN: begin
				raw_result = min_result;
				legal = zbb_on;
			end
			exu_pkg::OP_MINU: begin
				raw_result = minu_result;
				legal = zbb_on;
			end
			exu_pkg::OP_SEXTB: begin
				raw_result = sextb_result;
				legal = zbb_on;
			end
			exu_pkg::OP_SEXTH: begin
				raw_result = sexth_result;
				legal = zbb_on;
			end
			exu_pkg::OP_REV8: begin
				raw_result = rev8_result;
				legal = zbb_on;
			end
			exu_pkg::OP_ORCB: begin
				raw_result = orcb_result;
				legal = zbb_on;
			end
			exu_pkg::OP_ROL: begin
				raw_result = rol_result;
				legal = zbb_on;
			end
			exu_pkg::OP_ROR: begin
				raw_result = ror_result;
				legal = zbb_on;
			end
			default: legal = 1'b0;	// Codes 30, 31
		endcase
	end

	assign o_illegal = !legal;
	assign o_result = legal ? raw_result : '0;

endmodule

`default_nettype wire

//--- source/exu_ext_cfg.sv
// Extension enables and illegal-operation counter
// Writes land on the edge after i_cfg_we, counter saturates at all ones

`timescale 1ns/1ps
`default_nettype none

module exu_ext_cfg(
	input wire i_clk,
	input wire i_arst_n,

	input wire i_cfg_we,
	input wire [exu_pkg::EXT_W-1:0] i_cfg_enables,

	input wire i_illegal_retire,

	output logic [exu_pkg::EXT_W-1:0] o_enables,
	output logic [exu_pkg::CNT_W-1:0] o_illegal_count
);

	logic [exu_pkg::EXT_W-1:0] enables_q;
	logic [exu_pkg::CNT_W-1:0] count_q;
	logic count_full;

	assign count_full = &count_q;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			enables_q <= exu_pkg::EXT_RESET;
		end else if (i_cfg_we) begin
			enables_q <= i_cfg_enables;
		end
	end

	// Saturating count of illegal retirements
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			count_q <= '0;
		end else if (i_illegal_retire && !count_full) begin
			count_q <= count_q + 1'b1;
		end
	end

	assign o_enables = enables_q;
	assign o_illegal_count = count_q;

endmodule

`default_nettype wire

//--- source/exu_top.sv
// RV32 execute unit: request stage, ALU, response stage
// Two operations in flight at most, enables sampled in the ALU stage

`timescale 1ns/1ps
`default_nettype none

module exu_top(
	input wire i_clk,
	input wire i_arst_n,

	input wire i_req_valid,
	output logic o_req_ready,
	input wire [exu_pkg::OP_W-1:0] i_req_op,
	input wire [exu_pkg::XLEN-1:0] i_req_op1,
	input wire [exu_pkg::XLEN-1:0] i_req_op2,
	input wire [exu_pkg::TAG_W-1:0] i_req_tag,

	output logic o_rsp_valid,
	input wire i_rsp_ready,
	output logic [exu_pkg::XLEN-1:0] o_rsp_result,
	output logic o_rsp_illegal,
	output logic [exu_pkg::TAG_W-1:0] o_rsp_tag,

	input wire i_cfg_we,
	input wire [exu_pkg::EXT_W-1:0] i_cfg_enables,
	output logic [exu_pkg::EXT_W-1:0] o_cfg_enables,
	output logic [exu_pkg::CNT_W-1:0] o_illegal_count
);

	exu_pkg::exu_req_t req_d, req_q;
	exu_pkg::exu_rsp_t rsp_d, rsp_q;

	logic req_q_valid;
	logic rsp_in_ready;
	logic [exu_pkg::EXT_W-1:0] enables;

	assign req_d.op = i_req_op;
	assign req_d.op1 = i_req_op1;
	assign req_d.op2 = i_req_op2;
	assign req_d.tag = i_req_tag;

	exu_pipe_reg #(.T(exu_pkg::exu_req_t)) u_req_stage (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_valid(i_req_valid),
		.o_ready(o_req_ready),
		.i_data(req_d),
		.o_valid(req_q_valid),
		.i_ready(rsp_in_ready),
		.o_data(req_q)
	);

	exu_alu u_alu (
		.i_op(req_q.op),
		.i_op1(req_q.op1),
		.i_op2(req_q.op2),
		.i_enables(enables),
		.o_result(rsp_d.result),
		.o_illegal(rsp_d.illegal)
	);

	assign rsp_d.tag = req_q.tag;	// Tag rides along untouched

	exu_pipe_reg #(.T(exu_pkg::exu_rsp_t)) u_rsp_stage (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_valid(req_q_valid),
		.o_ready(rsp_in_ready),
		.i_data(rsp_d),
		.o_valid(o_rsp_valid),
		.i_ready(i_rsp_ready),
		.o_data(rsp_q)
	);

	assign o_rsp_result = rsp_q.result;
	assign o_rsp_illegal = rsp_q.illegal;
	assign o_rsp_tag = rsp_q.tag;

	exu_ext_cfg u_ext_cfg (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_cfg_we(i_cfg_we),
		.i_cfg_enables(i_cfg_enables),
		.i_illegal_retire(o_rsp_valid & i_rsp_ready & rsp_q.illegal),
		.o_enables(enables),
		.o_illegal_count(o_illegal_count)
	);

	assign o_cfg_enables = enables;

endmodule

`default_nettype wire

//--- sim/tb_exu_top.sv
// Self-checking testbench for exu_top with xorshift stimulus from a fixed seed
// Enables are rewritten only while the unit is empty

`timescale 1ns/1ps
`default_nettype none

module tb_exu_top;

	localparam int CLK_PERIOD = 8;
	localparam int TOTAL_OPS = 2000 + 1000 + 3 * 500 + 16;
	localparam int TIMEOUT_CYCLES = TOTAL_OPS * 20 + 2000;

	logic clk;
	logic i_arst_n;
	logic i_req_valid;
	logic o_req_ready;
	logic [exu_pkg::OP_W-1:0] i_req_op;
	logic [exu_pkg::XLEN-1:0] i_req_op1;
	logic [exu_pkg::XLEN-1:0] i_req_op2;
	logic [exu_pkg::TAG_W-1:0] i_req_tag;
	logic o_rsp_valid;
	logic i_rsp_ready;
	logic [exu_pkg::XLEN-1:0] o_rsp_result;
	logic o_rsp_illegal;
	logic [exu_pkg::TAG_W-1:0] o_rsp_tag;
	logic i_cfg_we;
	logic [exu_pkg::EXT_W-1:0] i_cfg_enables;
	logic [exu_pkg::EXT_W-1:0] o_cfg_enables;
	logic [exu_pkg::CNT_W-1:0] o_illegal_count;

	logic [31:0] rng_state = 32'hebb9_7db5;
	logic [exu_pkg::EXT_W-1:0] enables_model;
	logic [exu_pkg::TAG_W-1:0] tag_next;
	exu_pkg::exu_rsp_t expected_q[$];
	int err_count = 0;
	int test_err_base = 0;
	int tests_run = 0;
	int illegal_seen = 0;
	int rsp_seen = 0;
	int edge_no = 0;
	int first_acc_edge = -1;
	int first_rsp_edge = -1;
	int last_rsp_edge = -1;

	exu_top uut (
		.i_clk(clk),
		.i_arst_n(i_arst_n),
		.i_req_valid(i_req_valid),
		.o_req_ready(o_req_ready),
		.i_req_op(i_req_op),
		.i_req_op1(i_req_op1),
		.i_req_op2(i_req_op2),
		.i_req_tag(i_req_tag),
		.o_rsp_valid(o_rsp_valid),
		.i_rsp_ready(i_rsp_ready),
		.o_rsp_result(o_rsp_result),
		.o_rsp_illegal(o_rsp_illegal),
		.o_rsp_tag(o_rsp_tag),
		.i_cfg_we(i_cfg_we),
		.i_cfg_enables(i_cfg_enables),
		.o_cfg_enables(o_cfg_enables),
		.o_illegal_count(o_illegal_count)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic logic chance(input int pct);
		return (next_rand() % 100) < pct;
	endfunction

	// Corner values about a quarter of the time
	function automatic logic [31:0] pick_operand();
		logic [31:0] r;
		r = next_rand();
		case (r[3:0])
			4'd0: return 32'h0000_0000;
			4'd1: return 32'hffff_ffff;
			4'd2: return 32'h8000_0000;
			4'd3: return 32'h7fff_ffff;
			default: return next_rand();
		endcase
	endfunction

	// Returns {result, illegal}
	function automatic logic [32:0] model_alu(input logic [4:0] op, input logic [31:0] a,
			input logic [31:0] b, input logic [1:0] en);
		logic [31:0] r;
		logic [63:0] dbl;
		logic ok;
		int s;
		int i;
		s = b[4:0];
		r = '0;
		ok = 1'b1;
		case (op)
			exu_pkg::OP_ADD:    r = a + b;
			exu_pkg::OP_SUB:    r = a - b;
			exu_pkg::OP_AND:    r = a & b;
			exu_pkg::OP_OR:     r = a | b;
			exu_pkg::OP_XOR:    r = a ^ b;
			exu_pkg::OP_SLL:    r = a << s;
			exu_pkg::OP_SRL:    r = a >> s;
			exu_pkg::OP_SRA:    r = $signed(a) >>> s;
			exu_pkg::OP_SLT:    r = {31'b0, $signed(a) < $signed(b)};
			exu_pkg::OP_SLTU:   r = {31'b0, a < b};
			exu_pkg::OP_EQ:     r = {31'b0, a == b};
			exu_pkg::OP_NE:     r = {31'b0, a != b};
			exu_pkg::OP_GE:     r = {31'b0, $signed(a) >= $signed(b)};
			exu_pkg::OP_GEU:    r = {31'b0, a >= b};
			exu_pkg::OP_SH1ADD: r = a * 2 + b;
			exu_pkg::OP_SH2ADD: r = a * 4 + b;
			exu_pkg::OP_SH3ADD: r = a * 8 + b;
			exu_pkg::OP_ANDN:   r = a & ~b;
			exu_pkg::OP_ORN:    r = a | ~b;
			exu_pkg::OP_XNOR:   r = ~(a ^ b);
			exu_pkg::OP_MAX:    r = ($signed(a) > $signed(b)) ? a : b;
			exu_pkg::OP_MAXU:   r = (a > b) ? a : b;
			exu_pkg::OP_MIN:    r = ($signed(a) > $signed(b)) ? b : a;
			exu_pkg::OP_MINU:   r = (a > b) ? b : a;
			exu_pkg::OP_SEXTB:  r = $signed(a[7:0]);
			exu_pkg::OP_SEXTH:  r = $signed(a[15:0]);
			exu_pkg::OP_REV8: begin
				for (i = 0; i < 4; i++) r[8*i +: 8] = a[8*(3-i) +: 8];
			end
			exu_pkg::OP_ORCB: begin
				for (i = 0; i < 4; i++) r[8*i +: 8] = (a[8*i +: 8] != 0) ? 8'hff : 8'h00;
			end
			exu_pkg::OP_ROL: begin
				dbl = {a, a} << s;
				r = dbl[63:32];
			end
			exu_pkg::OP_ROR: begin
				dbl = {a, a} >> s;
				r = dbl[31:0];
			end
			default: r = '0;
		endcase
		if (op >= exu_pkg::OP_SH1ADD && op <= exu_pkg::OP_SH3ADD)
			ok = en[exu_pkg::EXT_ZBA];
		else if (op >= exu_pkg::OP_ANDN && op <= exu_pkg::OP_ROR)
			ok = en[exu_pkg::EXT_ZBB];
		else if (op > exu_pkg::OP_ROR)
			ok = 1'b0;	// Unused codes
		return {ok ? r : 32'h0, !ok};
	endfunction

	// Scoreboard pops before it pushes
	always @(posedge clk) begin : monitor
		exu_pkg::exu_rsp_t exp_item;
		logic [32:0] m;
		edge_no++;
		if (o_rsp_valid && i_rsp_ready) begin
			if (first_rsp_edge < 0) first_rsp_edge = edge_no;
			last_rsp_edge = edge_no;
			rsp_seen++;
			assert (expected_q.size() > 0) else begin
				$display("At %0t a response arrived with no request pending", $time);
				err_count++;
			end
			if (expected_q.size() > 0) begin
				exp_item = expected_q.pop_front();
				if (exp_item.illegal) illegal_seen++;
				assert (o_rsp_result === exp_item.result) else begin
					$display("[ERROR] %0t: result %h, expected %h (tag %0d)", $time,
						o_rsp_result, exp_item.result, exp_item.tag);
					err_count++;
				end
				assert (o_rsp_illegal === exp_item.illegal) else begin
					$display("[ERROR] %0t: illegal flag %b, expected %b (tag %0d)", $time,
						o_rsp_illegal, exp_item.illegal, exp_item.tag);
					err_count++;
				end
				assert (o_rsp_tag === exp_item.tag) else begin
					$display("[ERROR] %0t: tag %0d, expected %0d", $time, o_rsp_tag,
						exp_item.tag);
					err_count++;
				end
			end
		end
		if (i_req_valid && o_req_ready) begin
			if (first_acc_edge < 0) first_acc_edge = edge_no;
			m = model_alu(i_req_op, i_req_op1, i_req_op2, enables_model);
			exp_item.result = m[32:1];
			exp_item.illegal = m[0];
			exp_item.tag = i_req_tag;
			expected_q.push_back(exp_item);
		end
	end

	task automatic run_ops(input int n, input int op_count, input int valid_pct,
			input int ready_pct);
		int sent;
		logic [31:0] r;
		sent = 0;
		while (sent < n) begin
			@(posedge clk);
			if (i_req_valid && o_req_ready) sent++;
			if (!i_req_valid || o_req_ready) begin	// Payload may change
				if (sent < n && chance(valid_pct)) begin
					r = next_rand() % op_count;
					i_req_valid <= 1'b1;
					i_req_op <= r[4:0];
					i_req_op1 <= pick_operand();
					i_req_op2 <= pick_operand();
					i_req_tag <= tag_next;
					tag_next = tag_next + 1'b1;
				end else begin
					i_req_valid <= 1'b0;
				end
			end
			i_rsp_ready <= chance(ready_pct);
		end
	endtask

	task automatic drain_unit();
		i_req_valid <= 1'b0;
		i_rsp_ready <= 1'b1;
		@(negedge clk);	// Scoreboard has seen the last edge
		while (expected_q.size() != 0) @(negedge clk);
		repeat (2) @(posedge clk);
	endtask

	task automatic finish_test(input string name);
		drain_unit();
		assert (o_illegal_count == illegal_seen) else begin
			$display("[ERROR] %0t: illegal count %0d, expected %0d", $time,
				o_illegal_count, illegal_seen);
			err_count++;
		end
		$display("Test %s finished with %0d errors", name, err_count - test_err_base);
		test_err_base = err_count;
		tests_run++;
	endtask

	task automatic set_enables(input logic [1:0] en);
		@(posedge clk);
		i_cfg_we <= 1'b1;
		i_cfg_enables <= en;
		@(posedge clk);
		i_cfg_we <= 1'b0;
		@(posedge clk);
		enables_model = en;
		assert (o_cfg_enables == en) else begin
			$display("[ERROR] %0t: enables read %b, written %b", $time, o_cfg_enables, en);
			err_count++;
		end
	endtask

	initial begin : watchdog
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Watchdog: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		clk = 1'b0;
		i_arst_n = 1'b0;
		i_req_valid = 1'b0;
		i_req_op = '0;
		i_req_op1 = '0;
		i_req_op2 = '0;
		i_req_tag = '0;
		i_rsp_ready = 1'b0;
		i_cfg_we = 1'b0;
		i_cfg_enables = '0;
		enables_model = exu_pkg::EXT_RESET;
		tag_next = '0;
		repeat (8) @(posedge clk);
		i_arst_n <= 1'b1;
		@(posedge clk);
		assert (!o_rsp_valid && o_req_ready && o_cfg_enables == 2'b11
				&& o_illegal_count == 0) else begin
			$display("[ERROR] %0t: state after reset is wrong", $time);
			err_count++;
		end
		finish_test("reset");

		run_ops(2000, 30, 80, 100);
		finish_test("all_codes");
		run_ops(1000, 32, 70, 50);
		finish_test("stalls");

		set_enables(2'b01);	// Zba only
		run_ops(500, 32, 80, 70);
		finish_test("zbb_off");
		set_enables(2'b10);
		run_ops(500, 32, 80, 70);
		finish_test("zba_off");
		set_enables(2'b00);
		run_ops(500, 32, 80, 70);
		finish_test("both_off");
		set_enables(2'b11);

		first_acc_edge = -1;
		first_rsp_edge = -1;
		rsp_seen = 0;
		run_ops(16, 30, 100, 100);
		drain_unit();
		assert (first_rsp_edge - first_acc_edge == 2 && rsp_seen == 16
				&& last_rsp_edge - first_rsp_edge == 15) else begin
			$display("[ERROR] %0t: throughput off, first gap %0d, %0d responses in %0d edges",
				$time, first_rsp_edge - first_acc_edge, rsp_seen,
				last_rsp_edge - first_rsp_edge + 1);
			err_count++;
		end
		finish_test("throughput");

		$display("Tests run: %0d, queue left: %0d, errors: %0d", tests_run,
			expected_q.size(), err_count);
		if (err_count == 0 && expected_q.size() == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
source/exu_pkg.sv
source/exu_pipe_reg.sv
source/exu_alu.sv
source/exu_ext_cfg.sv
source/exu_top.sv
sim/tb_exu_top.sv

//--- Bender.yml
package:
  name: exu

sources:
  - source/exu_pkg.sv
  - source/exu_pipe_reg.sv
  - source/exu_alu.sv
  - source/exu_ext_cfg.sv
  - source/exu_top.sv
  - target: test
    files:
      - sim/tb_exu_top.sv
